//--- include/cdc_cfg.svh
`ifndef CDC_CFG_SVH
`define CDC_CFG_SVH

// ====================
// frame bytes
// ====================
`define CDC_SYNC_BYTE     8'hAA
`define CDC_ACK_BYTE      8'h55

// ====================
// flow control and buffering
// ====================
// inbound depth doubles as the host's starting credit count
`define CDC_RX_DEPTH      8
`define CDC_RESP_DEPTH    4
`define CDC_TX_CREDITS    4

// ====================
// sizes
// ====================
`define CDC_MAX_PAYLOAD   8
`define CDC_PWM_CHANNELS  8

`endif

//--- hdl/cmd_pkg.sv
package cmd_pkg;

`include "cdc_cfg.svh"

    // one beat of a usb byte stream
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } usb_byte_t;

    // payload lengths: ping 0, pwm set 5, dac set 3
    typedef enum logic [7:0] {
        CMD_PING    = 8'h00,
        CMD_PWM_SET = 8'h01,
        CMD_DAC_SET = 8'h02
    } cmd_code_e;

    typedef enum logic [7:0] {
        ST_OK      = 8'h00,
        ST_BAD_SUM = 8'h01,
        ST_BAD_CMD = 8'h02,
        ST_BAD_LEN = 8'h03
    } status_e;

    // decoded frame, payload byte 0 is the first one received
    typedef struct packed {
        cmd_code_e                         code;
        status_e                           status;
        logic [`CDC_MAX_PAYLOAD-1:0][7:0]  payload;
    } cmd_req_t;

    typedef struct packed {
        cmd_code_e code;
        status_e   status;
    } resp_t;

endpackage

//--- hdl/periph_pkg.sv
package periph_pkg;

`include "cdc_cfg.svh"

    typedef logic [$clog2(`CDC_PWM_CHANNELS)-1:0] pwm_chan_t;

    // counter-compare setting for one channel
    typedef struct packed {
        logic [15:0] period;
        logic [15:0] duty;
    } pwm_cfg_t;

    typedef struct packed {
        logic      valid;
        pwm_chan_t chan;
        pwm_cfg_t  cfg;
    } pwm_wr_t;

    typedef logic signed [13:0] dac_sample_t;

    // offset binary words, 14'h2000 is signed zero
    typedef struct packed {
        logic [13:0] a;
        logic [13:0] b;
    } dac_out_t;

endpackage

//--- hdl/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 8
) (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic push_i,
    input  T     wdata_i,
    output logic full_o,
    input  logic pop_i,
    output T     rdata_o,
    output logic empty_o
);

    localparam int            AW       = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [AW-1:0] LAST     = AW'(DEPTH - 1);
    localparam logic [AW:0]   FULL_CNT = (AW + 1)'(DEPTH);

    T              mem [DEPTH];
    logic [AW-1:0] wr_ptr_q;
    logic [AW-1:0] rd_ptr_q;
    logic [AW:0]   count_q;
    logic          do_push;
    logic          do_pop;

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;
    assign full_o  = (count_q == FULL_CNT);
    assign empty_o = (count_q == '0);
    assign rdata_o = mem[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr_q] <= wdata_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == LAST) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == LAST) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + (AW + 1)'(do_push) - (AW + 1)'(do_pop);
        end
    end

    // the producer must respect its credits or its ready
    push_full_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        push_i |-> !full_o) else $error("push into full FIFO");
    pop_empty_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pop_i |-> !empty_o) else $error("pop from empty FIFO");

endmodule

//--- hdl/frame_parser.sv
`timescale 1ns/1ps
`include "cdc_cfg.svh"

module frame_parser (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              byte_valid_i,
    input  logic [7:0]        byte_i,
    output logic              byte_pop_o,
    output logic              req_valid_o,
    output cmd_pkg::cmd_req_t req_o,
    input  logic              req_ready_i
);

    import cmd_pkg::*;

    localparam int PW = $clog2(`CDC_MAX_PAYLOAD);

    typedef enum logic [2:0] {
        S_HUNT, S_CODE, S_LEN, S_PAYLOAD, S_SUM, S_HOLD
    } state_e;

    state_e                           state_q;
    logic [7:0]                       code_q;
    logic [7:0]                       len_q;
    logic [7:0]                       cnt_q;
    logic [7:0]                       sum_q;
    status_e                          status_q;
    logic [`CDC_MAX_PAYLOAD-1:0][7:0] payload_q;
    logic [7:0]                       exp_len;
    logic                             code_known;

    // every byte is taken except while a request waits
    assign byte_pop_o  = byte_valid_i && (state_q != S_HOLD);
    assign req_valid_o = (state_q == S_HOLD);
    assign req_o       = '{code: cmd_code_e'(code_q), status: status_q, payload: payload_q};

    // expected length per code
    always_comb begin
        code_known = 1'b1;
        case (code_q)
            CMD_PING:    exp_len = 8'd0;
            CMD_PWM_SET: exp_len = 8'd5;
            CMD_DAC_SET: exp_len = 8'd3;
            default: begin
                exp_len    = 8'd0;
                code_known = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q  <= S_HUNT;
            code_q   <= '0;
            len_q    <= '0;
            cnt_q    <= '0;
            sum_q    <= '0;
            status_q <= ST_OK;
        end else begin
            case (state_q)
                S_HUNT: if (byte_valid_i && byte_i == `CDC_SYNC_BYTE) state_q <= S_CODE;
                S_CODE: if (byte_valid_i) begin
                    code_q  <= byte_i;
                    sum_q   <= byte_i;
                    state_q <= S_LEN;
                end
                S_LEN: if (byte_valid_i) begin
                    len_q   <= byte_i;
                    sum_q   <= sum_q + byte_i;
                    cnt_q   <= '0;
                    state_q <= (byte_i == 8'd0) ? S_SUM : S_PAYLOAD;
                end
                // oversize frames are still drained to their end
                S_PAYLOAD: if (byte_valid_i) begin
                    sum_q <= sum_q + byte_i;
                    cnt_q <= cnt_q + 8'd1;
                    if (cnt_q + 8'd1 == len_q) state_q <= S_SUM;
                end
                S_SUM: if (byte_valid_i) begin
                    if (sum_q != byte_i)     status_q <= ST_BAD_SUM;
                    else if (!code_known)    status_q <= ST_BAD_CMD;
                    else if (len_q != exp_len) status_q <= ST_BAD_LEN;
                    else                     status_q <= ST_OK;
                    state_q <= S_HOLD;
                end
                S_HOLD: if (req_ready_i) state_q <= S_HUNT;
                default: state_q <= S_HUNT;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == S_PAYLOAD && byte_valid_i && cnt_q < 8'(`CDC_MAX_PAYLOAD)) begin
            payload_q[cnt_q[PW-1:0]] <= byte_i;
        end
    end

endmodule

//--- hdl/cmd_dispatch.sv
`timescale 1ns/1ps

module cmd_dispatch (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 req_valid_i,
    input  cmd_pkg::cmd_req_t    req_i,
    output logic                 req_ready_o,
    output periph_pkg::pwm_wr_t  pwm_wr_o,
    output periph_pkg::dac_out_t dac_o,
    output logic                 resp_push_o,
    output cmd_pkg::resp_t       resp_o,
    input  logic                 resp_full_i
);

    import cmd_pkg::*;
    import periph_pkg::*;

    localparam logic [13:0] DAC_MID = 14'h2000;

    logic        accept;
    logic        req_ok;
    logic        pwm_valid_q;
    pwm_chan_t   pwm_chan_q;
    pwm_cfg_t    pwm_cfg_q;
    logic        push_q;
    resp_t       resp_q;
    dac_sample_t sample;
    logic [13:0] sample_ob;

    // a record still on its way to the FIFO counts as occupancy
    assign req_ready_o = !resp_full_i && !push_q;
    assign accept      = req_valid_i && req_ready_o;
    assign req_ok      = (req_i.status == ST_OK);

    // signed to offset binary by flipping the sign bit
    assign sample    = dac_sample_t'({req_i.payload[1][5:0], req_i.payload[2]});
    assign sample_ob = {~sample[13], sample[12:0]};

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pwm_valid_q <= 1'b0;
            push_q      <= 1'b0;
            dac_o       <= '{a: DAC_MID, b: DAC_MID};
        end else begin
            pwm_valid_q <= accept && req_ok && (req_i.code == CMD_PWM_SET);
            push_q      <= accept;
            if (accept && req_ok && req_i.code == CMD_DAC_SET) begin
                if (req_i.payload[0][0]) dac_o.b <= sample_ob;
                else                     dac_o.a <= sample_ob;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            pwm_chan_q <= pwm_chan_t'(req_i.payload[0]);
            pwm_cfg_q  <= '{period: {req_i.payload[1], req_i.payload[2]},
                            duty:   {req_i.payload[3], req_i.payload[4]}};
            resp_q     <= '{code: req_i.code, status: req_i.status};
        end
    end

    assign pwm_wr_o    = '{valid: pwm_valid_q, chan: pwm_chan_q, cfg: pwm_cfg_q};
    assign resp_push_o = push_q;
    assign resp_o      = resp_q;

    // a PWM write goes out together with the OK record of its own frame
    pwm_ok_only_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pwm_wr_o.valid |-> resp_push_o && resp_o.status == ST_OK &&
                           resp_o.code == CMD_PWM_SET)
        else $error("PWM write from a request that was not ST_OK");

endmodule

//--- hdl/pwm_bank.sv
`timescale 1ns/1ps
`include "cdc_cfg.svh"

module pwm_bank (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  periph_pkg::pwm_wr_t          pwm_wr_i,
    output logic [`CDC_PWM_CHANNELS-1:0] pwm_o
);

    import periph_pkg::*;

    for (genvar ch = 0; ch < `CDC_PWM_CHANNELS; ch++) begin : g_chan
        pwm_cfg_t    pend_q;
        pwm_cfg_t    act_q;
        logic [15:0] cnt_q;
        logic        out_q;
        logic        sel;
        logic        wrap;

        assign sel  = pwm_wr_i.valid && (pwm_wr_i.chan == pwm_chan_t'(ch));
        // period 0 wraps every cycle, so a new setting loads at once
        assign wrap = (act_q.period == 16'd0) || (cnt_q == act_q.period - 16'd1);

        always_ff @(posedge clk_i or negedge rst_n_i) begin
            if (!rst_n_i) begin
                pend_q <= '0;
                act_q  <= '0;
                cnt_q  <= '0;
                out_q  <= 1'b0;
            end else begin
                if (sel) pend_q <= pwm_wr_i.cfg;
                // pending setting goes live only at the wrap
                if (wrap) begin
                    act_q <= pend_q;
                    cnt_q <= '0;
                end else begin
                    cnt_q <= cnt_q + 16'd1;
                end
                out_q <= (act_q.period != 16'd0) && (cnt_q < act_q.duty);
            end
        end

        assign pwm_o[ch] = out_q;
    end

endmodule

//--- hdl/upload_framer.sv
`timescale 1ns/1ps
`include "cdc_cfg.svh"

module upload_framer (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               resp_valid_i,
    input  cmd_pkg::resp_t     resp_i,
    output logic               resp_pop_o,
    input  logic               tx_credit_i,
    output cmd_pkg::usb_byte_t usb_tx_o
);

    import cmd_pkg::*;

    localparam int            CW          = $clog2(`CDC_TX_CREDITS + 1);
    localparam logic [CW-1:0] CREDIT_INIT = CW'(`CDC_TX_CREDITS);

    logic [CW-1:0] credit_q;
    logic [1:0]    idx_q;
    logic          send;
    logic [7:0]    tx_byte;
    logic          tx_valid_q;
    logic [7:0]    tx_data_q;

    // record stays at the FIFO head until the checksum byte goes out
    assign send       = resp_valid_i && (credit_q != '0);
    assign resp_pop_o = send && (idx_q == 2'd3);

    always_comb begin
        case (idx_q)
            2'd0:    tx_byte = `CDC_ACK_BYTE;
            2'd1:    tx_byte = resp_i.code;
            2'd2:    tx_byte = resp_i.status;
            default: tx_byte = 8'(resp_i.code) + 8'(resp_i.status);
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            credit_q   <= CREDIT_INIT;
            idx_q      <= '0;
            tx_valid_q <= 1'b0;
        end else begin
            tx_valid_q <= send;
            if (send) idx_q <= idx_q + 2'd1;
            case ({tx_credit_i, send})
                2'b10:   credit_q <= credit_q + CW'(1);
                2'b01:   credit_q <= credit_q - CW'(1);
                default: credit_q <= credit_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (send) tx_data_q <= tx_byte;
    end

    assign usb_tx_o = '{valid: tx_valid_q, data: tx_data_q};

    // host may only hand back what it was given
    credit_max_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        credit_q <= CREDIT_INIT) else $error("upload credits over limit");

endmodule

//--- hdl/cdc_core.sv
`timescale 1ns/1ps
`include "cdc_cfg.svh"

module cdc_core (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  cmd_pkg::usb_byte_t           usb_rx_i,
    output logic                         rx_credit_o,
    output cmd_pkg::usb_byte_t           usb_tx_o,
    input  logic                         tx_credit_i,
    output logic [`CDC_PWM_CHANNELS-1:0] pwm_o,
    output periph_pkg::dac_out_t         dac_o
);

    import cmd_pkg::*;
    import periph_pkg::*;

    logic       rx_empty;
    logic [7:0] rx_data;
    logic       rx_pop;
    logic       req_valid;
    logic       req_ready;
    cmd_req_t   req;
    pwm_wr_t    pwm_wr;
    logic       resp_push;
    resp_t      resp_wr;
    logic       resp_full;
    logic       resp_pop;
    resp_t      resp_rd;
    logic       resp_empty;

    // ====================
    // inbound path
    // ====================
    sync_fifo #(.T(logic [7:0]), .DEPTH(`CDC_RX_DEPTH)) u_rx_fifo (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .push_i(usb_rx_i.valid), .wdata_i(usb_rx_i.data),
        .full_o(), .pop_i(rx_pop), .rdata_o(rx_data), .empty_o(rx_empty));

    // one credit back per consumed byte
    assign rx_credit_o = rx_pop;

    frame_parser u_parser (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .byte_valid_i(!rx_empty), .byte_i(rx_data),
        .byte_pop_o(rx_pop), .req_valid_o(req_valid), .req_o(req), .req_ready_i(req_ready));

    // ====================
    // execution
    // ====================
    cmd_dispatch u_dispatch (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .req_valid_i(req_valid), .req_i(req),
        .req_ready_o(req_ready), .pwm_wr_o(pwm_wr), .dac_o(dac_o),
        .resp_push_o(resp_push), .resp_o(resp_wr), .resp_full_i(resp_full));

    pwm_bank u_pwm (.clk_i(clk_i), .rst_n_i(rst_n_i), .pwm_wr_i(pwm_wr), .pwm_o(pwm_o));

    // ====================
    // upload path
    // ====================
    sync_fifo #(.T(resp_t), .DEPTH(`CDC_RESP_DEPTH)) u_resp_fifo (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .push_i(resp_push), .wdata_i(resp_wr),
        .full_o(resp_full), .pop_i(resp_pop), .rdata_o(resp_rd), .empty_o(resp_empty));

    upload_framer u_framer (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .resp_valid_i(!resp_empty), .resp_i(resp_rd),
        .resp_pop_o(resp_pop), .tx_credit_i(tx_credit_i), .usb_tx_o(usb_tx_o));

endmodule

//--- verif/tb_cdc_core.sv
`timescale 1ns/1ps
`include "cdc_cfg.svh"

module tb_cdc_core;

    import cmd_pkg::*;
    import periph_pkg::*;

    localparam int TIMEOUT_CYCLES = 20000;

    logic                         clk = 1'b0;
    logic                         rst_n = 1'b0;
    usb_byte_t                    usb_rx = '0;
    logic                         rx_credit;
    usb_byte_t                    usb_tx;
    logic                         tx_credit = 1'b0;
    logic [`CDC_PWM_CHANNELS-1:0] pwm_o;
    dac_out_t                     dac_o;

    // host side state
    logic [7:0]  host_q [$];
    logic [7:0]  tx_q [$];
    int          rx_credits = `CDC_RX_DEPTH;
    int          tx_owed = 0;
    bit          tx_hold = 1'b0;
    bit          stall_ok = 1'b0;
    int          starve_cycles = 0;
    int          errors = 0;
    int          cycle_cnt;
    dac_out_t    exp_dac;
    logic [15:0] chan_period [8] = '{default: 16'd0};

    cdc_core dut0 (
        .clk_i(clk), .rst_n_i(rst_n), .usb_rx_i(usb_rx), .rx_credit_o(rx_credit),
        .usb_tx_o(usb_tx), .tx_credit_i(tx_credit), .pwm_o(pwm_o), .dac_o(dac_o));

    initial begin
        forever #5 clk = ~clk;
    end

    // ====================
    // host model
    // ====================
    always @(negedge clk) begin
        if (!rst_n) begin
            usb_rx = '0;
            tx_credit = 1'b0;
            rx_credits = `CDC_RX_DEPTH;
            tx_owed = 0;
        end else begin
            if (!stall_ok && host_q.size() != 0 && rx_credits == 0) starve_cycles++;
            if (rx_credits != 0 && host_q.size() != 0) begin
                usb_rx.valid = 1'b1;
                usb_rx.data = host_q.pop_front();
                rx_credits--;
            end else begin
                usb_rx = '0;
            end
            // credit seen now is spent from the next falling edge on
            if (rx_credit) rx_credits++;
            if (usb_tx.valid) begin
                tx_q.push_back(usb_tx.data);
                tx_owed++;
            end
            if (!tx_hold && tx_owed != 0) begin
                tx_credit = 1'b1;
                tx_owed--;
            end else begin
                tx_credit = 1'b0;
            end
        end
    end

    // ====================
    // compare tasks
    // ====================
    task automatic check_resp(input string name, input resp_t exp, input resp_t act);
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected code %h status %h, actual code %h status %h",
                     name, exp.code, exp.status, act.code, act.status);
        end
    endtask

    task automatic check_dac(input string name, input dac_out_t exp, input dac_out_t act);
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected a %h b %h, actual a %h b %h",
                     name, exp.a, exp.b, act.a, act.b);
        end
    endtask

    task automatic check_duty(input string name, input logic [15:0] exp, input logic [15:0] act);
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected %0d high cycles, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    function automatic resp_t ack_of(input cmd_code_e code, input status_e status);
        resp_t r;
        r.code = code;
        r.status = status;
        return r;
    endfunction

    // sync, code, length, payload, sum of code, length and payload
    task automatic send_frame(input logic [7:0] code, input int len,
                              input logic [7:0][7:0] pl, input bit corrupt);
        logic [7:0] sum;
        sum = code + 8'(len);
        host_q.push_back(`CDC_SYNC_BYTE);
        host_q.push_back(code);
        host_q.push_back(8'(len));
        for (int i = 0; i < len; i++) begin
            host_q.push_back(pl[i]);
            sum = sum + pl[i];
        end
        if (corrupt) sum = ~sum;
        host_q.push_back(sum);
    endtask

    task automatic send_pwm(input logic [2:0] ch, input logic [15:0] period,
                            input logic [15:0] duty);
        logic [7:0][7:0] pl;
        pl = '0;
        pl[0] = {5'd0, ch};
        pl[1] = period[15:8];
        pl[2] = period[7:0];
        pl[3] = duty[15:8];
        pl[4] = duty[7:0];
        send_frame(CMD_PWM_SET, 5, pl, 1'b0);
    endtask

    task automatic send_dac(input logic sel, input dac_sample_t v, input bit corrupt);
        logic [7:0][7:0] pl;
        pl = '0;
        pl[0] = {7'd0, sel};
        pl[1] = {2'b00, v[13:8]};
        pl[2] = v[7:0];
        send_frame(CMD_DAC_SET, 3, pl, corrupt);
    endtask

    task automatic expect_ack(input string name, input resp_t exp);
        logic [7:0] b [4];
        resp_t      act;
        while (tx_q.size() < 4) @(negedge clk);
        for (int i = 0; i < 4; i++) b[i] = tx_q.pop_front();
        act = {b[1], b[2]};
        check_byte({name, " sync"}, `CDC_ACK_BYTE, b[0]);
        check_resp(name, exp, act);
        check_byte({name, " checksum"}, 8'(exp.code) + 8'(exp.status), b[3]);
    endtask

    // ====================
    // directed tests
    // ====================
    task automatic reset_state();
        exp_dac.a = 14'h2000;
        exp_dac.b = 14'h2000;
        check_byte("reset pwm", 8'h00, pwm_o);
        check_dac("reset dac", exp_dac, dac_o);
        repeat (20) @(negedge clk);
        if (tx_q.size() != 0) begin
            errors++;
            $display("reset: upload byte appeared with no request sent");
        end
        send_frame(CMD_PING, 0, '0, 1'b0);
        expect_ack("reset ping", ack_of(CMD_PING, ST_OK));
    endtask

    task automatic pwm_duty();
        logic [2:0]  ch;
        logic [15:0] period;
        logic [15:0] duty;
        logic [15:0] old_period;
        logic [15:0] high;
        for (int n = 0; n < 4; n++) begin
            ch = 3'($urandom_range(7, 0));
            period = 16'($urandom_range(40, 4));
            duty = 16'($urandom_range(48, 0));
            old_period = chan_period[ch];
            send_pwm(ch, period, duty);
            expect_ack($sformatf("pwm ack ch%0d", ch), ack_of(CMD_PWM_SET, ST_OK));
            chan_period[ch] = period;
            // old setting runs to its wrap, then two new periods
            repeat (int'(old_period) + 2 * int'(period)) @(negedge clk);
            high = '0;
            repeat (10 * int'(period)) begin
                @(negedge clk);
                if (pwm_o[ch]) high++;
            end
            check_duty($sformatf("pwm duty ch%0d", ch),
                       (duty < period ? duty : period) * 16'd10, high);
        end
    endtask

    task automatic dac_words();
        logic        sel;
        dac_sample_t v;
        logic [13:0] word;
        for (int n = 0; n < 6; n++) begin
            sel = 1'($urandom_range(1, 0));
            v = dac_sample_t'($urandom_range(16383, 0));
            send_dac(sel, v, 1'b0);
            expect_ack("dac ack", ack_of(CMD_DAC_SET, ST_OK));
            word = 14'((int'(v) + 8192) % 16384);
            if (sel) exp_dac.b = word;
            else exp_dac.a = word;
            check_dac($sformatf("dac set %0d", n), exp_dac, dac_o);
        end
    endtask

    task automatic error_frames();
        logic [7:0][7:0] pl;
        logic [7:0]      junk;
        pl = '0;
        send_dac(1'b1, dac_sample_t'($urandom_range(16383, 0)), 1'b1);
        expect_ack("bad sum", ack_of(CMD_DAC_SET, ST_BAD_SUM));
        check_dac("bad sum dac", exp_dac, dac_o);
        send_frame(8'h07, 0, pl, 1'b0);
        expect_ack("bad cmd", ack_of(cmd_code_e'(8'h07), ST_BAD_CMD));
        pl[0] = 8'h3c;
        pl[1] = 8'hc3;
        send_frame(CMD_PING, 2, pl, 1'b0);
        expect_ack("bad len", ack_of(CMD_PING, ST_BAD_LEN));
        for (int i = 0; i < 3; i++) begin
            junk = 8'($urandom_range(255, 0));
            if (junk == `CDC_SYNC_BYTE) junk = 8'h5a;
            host_q.push_back(junk);
        end
        send_frame(CMD_PING, 0, '0, 1'b0);
        expect_ack("junk then ping", ack_of(CMD_PING, ST_OK));
        repeat (40) @(negedge clk);
        if (tx_q.size() != 0) begin
            errors++;
            $display("junk: %0d extra upload bytes after junk input", tx_q.size());
        end
    endtask

    task automatic back_pressure();
        cmd_code_e seq [6] = '{CMD_PWM_SET, CMD_PING, CMD_PWM_SET,
                               CMD_PING, CMD_PING, CMD_PWM_SET};
        // first ping uses up the framer's starting credits
        tx_hold = 1'b1;
        send_frame(CMD_PING, 0, '0, 1'b0);
        expect_ack("bp drain", ack_of(CMD_PING, ST_OK));
        stall_ok = 1'b1;
        for (int n = 0; n < 6; n++) begin
            if (seq[n] == CMD_PWM_SET) begin
                send_pwm(3'($urandom_range(7, 0)), 16'($urandom_range(40, 4)),
                         16'($urandom_range(40, 0)));
            end else begin
                send_frame(CMD_PING, 0, '0, 1'b0);
            end
        end
        repeat (150) @(negedge clk);
        if (tx_q.size() != 0) begin
            errors++;
            $display("back-pressure: upload bytes sent while credits were withheld");
        end
        // 4 records queued, 1 held in the parser, 8 bytes of the last frame buffered
        if (rx_credits != 0 || host_q.size() != 1) begin
            errors++;
            $display("back-pressure: inbound did not stall, credits %0d, bytes waiting %0d",
                     rx_credits, host_q.size());
        end
        tx_hold = 1'b0;
        for (int n = 0; n < 6; n++) begin
            expect_ack($sformatf("bp ack %0d", n), ack_of(seq[n], ST_OK));
        end
        while (host_q.size() != 0 || rx_credits != `CDC_RX_DEPTH) @(negedge clk);
        stall_ok = 1'b0;
    endtask

    // ====================
    // run control
    // ====================
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h1abd912c));
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        reset_state();
        pwm_duty();
        dac_words();
        error_frames();
        back_pressure();
        if (starve_cycles != 0) begin
            errors++;
            $display("host ran out of rx credits for %0d cycles with no stall", starve_cycles);
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+include
hdl/cmd_pkg.sv
hdl/periph_pkg.sv
hdl/sync_fifo.sv
hdl/frame_parser.sv
hdl/cmd_dispatch.sv
hdl/pwm_bank.sv
hdl/upload_framer.sv
hdl/cdc_core.sv
verif/tb_cdc_core.sv

//--- run_sim.sh
#!/bin/sh
# build and run the cdc_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module tb_cdc_core -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/Vtb_cdc_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
